//--- flist.f
rtl/tpu_cfg_pkg.sv
rtl/tpu_ctrl_pkg.sv
rtl/tpu_pe.sv
rtl/tpu_pe_array.sv
rtl/tpu_operand_skew.sv
rtl/tpu_ctrl.sv
rtl/tpu_top.sv
tb/tb_tpu.sv

//--- rtl/tpu_cfg_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Array geometry and data widths
// ---------------------------------------------------------------------------
package tpu_cfg_pkg;

    // Cells per side of the systolic grid
    localparam int ARRAY_DIM = 4;

    // Operand element and accumulator widths
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;

    // Job dimension inputs and memory indices
    localparam int DIM_W  = 8;
    localparam int ADDR_W = 12;

    // Packed memory words
    localparam int OP_WORD_W  = ARRAY_DIM * ELEM_W;
    localparam int ROW_WORD_W = ARRAY_DIM * ACC_W;

    // Drain row select
    localparam int ROW_SEL_W = $clog2(ARRAY_DIM);

endpackage

`default_nettype wire

//--- rtl/tpu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_ctrl
    import tpu_cfg_pkg::*, tpu_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [DIM_W-1:0]      K,
    input  logic [DIM_W-1:0]      M,
    input  logic [DIM_W-1:0]      N,
    output logic                  busy,
    output logic [ADDR_W-1:0]     operand_index,
    output logic                  feed_en,
    output logic [DIM_W-1:0]      m_dim,
    output logic [DIM_W-1:0]      n_dim,
    output logic                  flush,
    output logic [ROW_SEL_W-1:0]  drain_row,
    input  logic [ROW_WORD_W-1:0] row_data,
    output logic                  C_wr_en,
    output logic [ADDR_W-1:0]     C_index,
    output logic [ROW_WORD_W-1:0] C_data_in
);

    tpu_state_e state;
    tpu_state_e state_nxt;

    logic [DIM_W-1:0] k_dim;
    logic [CNT_W-1:0] calc_cnt;
    logic             accept;
    logic             calc_last;
    logic             drain_last;

    // ------------------------------------------------------------------------
    // Job acceptance and dimension capture
    // ------------------------------------------------------------------------

    assign accept = (state == ST_IDLE) && in_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_dim <= '0;
            m_dim <= '0;
            n_dim <= '0;
        end else if (accept) begin
            k_dim <= K;
            m_dim <= M;
            n_dim <= N;
        end
    end

    // ------------------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------------------

    // Last CALC cycle is offset K + FILL_CYCLES - 1
    assign calc_last = (calc_cnt == CNT_W'(k_dim) + CNT_W'(FILL_CYCLES - 1));

    // Stop at row M-1, never past the array edge
    assign drain_last = (DIM_W'(drain_row) == m_dim - DIM_W'(1)) ||
                        (drain_row == ROW_SEL_W'(ARRAY_DIM - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            calc_cnt <= '0;
        end else if (state == ST_CALC) begin
            calc_cnt <= calc_last ? '0 : calc_cnt + CNT_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_row <= '0;
        end else if (state == ST_DRAIN) begin
            drain_row <= drain_last ? '0 : drain_row + ROW_SEL_W'(1);
        end
    end

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (in_valid)   state_nxt = ST_CALC;
            ST_CALC:  if (calc_last)  state_nxt = ST_DRAIN;
            ST_DRAIN: if (drain_last) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            flush <= 1'b0;
        end else begin
            state <= state_nxt;
            // High for the first idle cycle after the drain
            flush <= (state == ST_DRAIN) && drain_last;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    assign busy    = (state != ST_IDLE);
    assign feed_en = (state == ST_CALC) && (calc_cnt < CNT_W'(k_dim));

    // One A word and one B word per cycle, same index for both
    assign operand_index = feed_en ? ADDR_W'(calc_cnt) : '0;

    assign C_wr_en   = (state == ST_DRAIN);
    assign C_index   = C_wr_en ? ADDR_W'(drain_row) : '0;
    assign C_data_in = C_wr_en ? row_data : '0;

endmodule

`default_nettype wire

//--- rtl/tpu_ctrl_pkg.sv
`default_nettype none

package tpu_ctrl_pkg;
    import tpu_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DRAIN
    } tpu_state_e;

    // Skew plus hop latency from the last operand word to the far corner cell
    localparam int FILL_CYCLES = 2 * ARRAY_DIM - 1;

    // Holds K + FILL_CYCLES for the largest K
    localparam int CNT_W = DIM_W + 1;

endpackage

`default_nettype wire

//--- rtl/tpu_operand_skew.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_operand_skew
    import tpu_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 feed_en,
    input  logic [DIM_W-1:0]     dim,
    input  logic [OP_WORD_W-1:0] mem_word,
    output logic [OP_WORD_W-1:0] lanes
);

    genvar i;

    generate
        for (i = 0; i < ARRAY_DIM; i++) begin : g_lane
            logic [ELEM_W-1:0] elem;

            // Lanes outside the tile inject zero
            assign elem = (feed_en && (DIM_W'(i) < dim)) ?
                          mem_word[OP_WORD_W-1-i*ELEM_W -: ELEM_W] : '0;

            if (i == 0) begin : g_direct
                assign lanes[OP_WORD_W-1 -: ELEM_W] = elem;
            end else begin : g_delay
                // i-deep shift register so lane i trails lane 0 by i cycles
                logic [ELEM_W-1:0] sr [i];

                always_ff @(posedge clk or negedge rst_n) begin
                    if (!rst_n) begin
                        for (int s = 0; s < i; s++) begin
                            sr[s] <= '0;
                        end
                    end else begin
                        sr[0] <= elem;
                        for (int s = 1; s < i; s++) begin
                            sr[s] <= sr[s-1];
                        end
                    end
                end

                assign lanes[OP_WORD_W-1-i*ELEM_W -: ELEM_W] = sr[i-1];
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- rtl/tpu_pe.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_pe
    import tpu_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic [ELEM_W-1:0] north_in,
    input  logic [ELEM_W-1:0] west_in,
    output logic [ELEM_W-1:0] south_out,
    output logic [ELEM_W-1:0] east_out,
    output logic [ACC_W-1:0]  acc
);

    logic [2*ELEM_W-1:0] prod;

    // Unsigned 8x8 product
    assign prod = west_in * north_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            south_out <= '0;
            east_out  <= '0;
            acc       <= '0;
        end else if (flush) begin
            south_out <= '0;
            east_out  <= '0;
            acc       <= '0;
        end else begin
            // One hop per cycle in each direction
            south_out <= north_in;
            east_out  <= west_in;
            acc       <= acc + ACC_W'(prod);
        end
    end

endmodule

`default_nettype wire

//--- rtl/tpu_pe_array.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_pe_array
    import tpu_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic [OP_WORD_W-1:0]  west_lanes,
    input  logic [OP_WORD_W-1:0]  north_lanes,
    input  logic [ROW_SEL_W-1:0]  drain_row,
    output logic [ROW_WORD_W-1:0] row_data
);

    // ------------------------------------------------------------------------
    // Operand links between cells
    // ------------------------------------------------------------------------

    // h_link[i][j] enters cell (i,j) from the west; column 0 is the array edge
    logic [ELEM_W-1:0] h_link [ARRAY_DIM][ARRAY_DIM+1];
    // v_link[i][j] enters cell (i,j) from the north; row 0 is the array edge
    logic [ELEM_W-1:0] v_link [ARRAY_DIM+1][ARRAY_DIM];

    // Accumulators packed per row, column 0 in the top word
    logic [ROW_WORD_W-1:0] row_words [ARRAY_DIM];

    genvar i;
    genvar j;

    generate
        for (i = 0; i < ARRAY_DIM; i++) begin : g_edge
            assign h_link[i][0] = west_lanes[OP_WORD_W-1-i*ELEM_W -: ELEM_W];
            assign v_link[0][i] = north_lanes[OP_WORD_W-1-i*ELEM_W -: ELEM_W];
        end
    endgenerate

    // ------------------------------------------------------------------------
    // Cell grid
    // ------------------------------------------------------------------------

    generate
        for (i = 0; i < ARRAY_DIM; i++) begin : g_row
            for (j = 0; j < ARRAY_DIM; j++) begin : g_col
                tpu_pe pe (
                    .clk       (clk),
                    .rst_n     (rst_n),
                    .flush     (flush),
                    .north_in  (v_link[i][j]),
                    .west_in   (h_link[i][j]),
                    .south_out (v_link[i+1][j]),
                    .east_out  (h_link[i][j+1]),
                    .acc       (row_words[i][ROW_WORD_W-1-j*ACC_W -: ACC_W])
                );
            end
        end
    endgenerate

    // ------------------------------------------------------------------------
    // Drain row select
    // ------------------------------------------------------------------------

    assign row_data = row_words[drain_row];

endmodule

`default_nettype wire

//--- rtl/tpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_top
    import tpu_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [DIM_W-1:0]      K,
    input  logic [DIM_W-1:0]      M,
    input  logic [DIM_W-1:0]      N,
    output logic                  busy,
    output logic [ADDR_W-1:0]     A_index,
    input  logic [OP_WORD_W-1:0]  A_data_out,
    output logic [ADDR_W-1:0]     B_index,
    input  logic [OP_WORD_W-1:0]  B_data_out,
    output logic                  C_wr_en,
    output logic [ADDR_W-1:0]     C_index,
    output logic [ROW_WORD_W-1:0] C_data_in
);

    logic [ADDR_W-1:0]     operand_index;
    logic                  feed_en;
    logic [DIM_W-1:0]      m_dim;
    logic [DIM_W-1:0]      n_dim;
    logic                  flush;
    logic [ROW_SEL_W-1:0]  drain_row;
    logic [ROW_WORD_W-1:0] row_data;
    logic [OP_WORD_W-1:0]  west_lanes;
    logic [OP_WORD_W-1:0]  north_lanes;

    assign A_index = operand_index;
    assign B_index = operand_index;

    tpu_ctrl ctrl0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .K             (K),
        .M             (M),
        .N             (N),
        .busy          (busy),
        .operand_index (operand_index),
        .feed_en       (feed_en),
        .m_dim         (m_dim),
        .n_dim         (n_dim),
        .flush         (flush),
        .drain_row     (drain_row),
        .row_data      (row_data),
        .C_wr_en       (C_wr_en),
        .C_index       (C_index),
        .C_data_in     (C_data_in)
    );

    // A columns enter from the west, masked by M
    tpu_operand_skew skew_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .feed_en  (feed_en),
        .dim      (m_dim),
        .mem_word (A_data_out),
        .lanes    (west_lanes)
    );

    // B rows enter from the north, masked by N
    tpu_operand_skew skew_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .feed_en  (feed_en),
        .dim      (n_dim),
        .mem_word (B_data_out),
        .lanes    (north_lanes)
    );

    tpu_pe_array array0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .west_lanes  (west_lanes),
        .north_lanes (north_lanes),
        .drain_row   (drain_row),
        .row_data    (row_data)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the TPU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_tpu -f flist.f -o tb_tpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_tpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb/tb_tpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tpu
    import tpu_cfg_pkg::*, tpu_ctrl_pkg::*;
();

    localparam logic [31:0] SEED = 32'heb5c_9a60;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    // Job table: full tile, partial tile, shortest job, back-to-back pair
    localparam int NUM_JOBS = 5;
    localparam int JOB_K [NUM_JOBS] = '{6, 5, 1, 4, 7};
    localparam int JOB_M [NUM_JOBS] = '{4, 2, 4, 3, 4};
    localparam int JOB_N [NUM_JOBS] = '{4, 3, 4, 4, 2};

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic [DIM_W-1:0]      k_in;
    logic [DIM_W-1:0]      m_in;
    logic [DIM_W-1:0]      n_in;
    logic                  busy;
    logic [ADDR_W-1:0]     a_index;
    logic [ADDR_W-1:0]     b_index;
    logic [OP_WORD_W-1:0]  a_data;
    logic [OP_WORD_W-1:0]  b_data;
    logic                  c_wr_en;
    logic [ADDR_W-1:0]     c_index;
    logic [ROW_WORD_W-1:0] c_data;

    logic [OP_WORD_W-1:0]  a_mem [MEM_DEPTH];
    logic [OP_WORD_W-1:0]  b_mem [MEM_DEPTH];
    logic [ROW_WORD_W-1:0] c_mem [ARRAY_DIM];
    logic [ROW_WORD_W-1:0] c_exp [ARRAY_DIM];
    logic                  c_written [ARRAY_DIM];

    int    errors = 0;
    int    jobs = 0;
    int    cycle_cnt = 0;
    int    timeout_cycles = 0;
    string test_name = "reset";
    int    cur_m = 0;
    // Job tracking in the monitor
    int    busy_cnt = 0;
    int    job_k = 0;
    int    job_m = 0;
    int    acc_k = 0;
    int    acc_m = 0;

    tpu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .K          (k_in),
        .M          (m_in),
        .N          (n_in),
        .busy       (busy),
        .A_index    (a_index),
        .A_data_out (a_data),
        .B_index    (b_index),
        .B_data_out (b_data),
        .C_wr_en    (c_wr_en),
        .C_index    (c_index),
        .C_data_in  (c_data)
    );

    // Combinational-read operand memories
    assign a_data = a_mem[a_index];
    assign b_data = b_mem[b_index];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("Timeout after %0d cycles, the DUT never finished its job", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Handshake properties
    // ------------------------------------------------------------------------

    busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && in_valid) |=> busy)
        else begin
            errors++;
            $display("%s: busy did not rise one cycle after acceptance", test_name);
        end

    no_spurious_start: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && !in_valid) |=> !busy)
        else begin
            errors++;
            $display("%s: busy rose without an accepted job", test_name);
        end

    // ------------------------------------------------------------------------
    // Job timing monitor and C memory sampled mid-cycle
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (!rst_n) begin
            busy_cnt = 0;
        end else if (busy) begin
            if (busy_cnt == 0) begin
                job_k = acc_k;
                job_m = acc_m;
            end
            if (busy_cnt < job_k) begin
                assert (a_index == ADDR_W'(busy_cnt) && b_index == ADDR_W'(busy_cnt))
                    else begin
                        errors++;
                        $display("MISMATCH %s operand index expected %0d actual %0d/%0d",
                                 test_name, busy_cnt, a_index, b_index);
                    end
            end
            if (busy_cnt >= job_k + FILL_CYCLES) begin
                assert (c_wr_en && c_index == ADDR_W'(busy_cnt - job_k - FILL_CYCLES))
                    else begin
                        errors++;
                        $display("MISMATCH %s C write index expected %0d actual en=%0b idx=%0d",
                                 test_name, busy_cnt - job_k - FILL_CYCLES, c_wr_en, c_index);
                    end
            end else begin
                assert (!c_wr_en)
                    else begin
                        errors++;
                        $display("%s: C written before the drain phase", test_name);
                    end
            end
            if (c_wr_en && c_index < ADDR_W'(ARRAY_DIM)) begin
                c_mem[c_index[ROW_SEL_W-1:0]] = c_data;
                c_written[c_index[ROW_SEL_W-1:0]] = 1'b1;
            end
            busy_cnt++;
        end else begin
            assert (!c_wr_en)
                else begin
                    errors++;
                    $display("%s: C written while idle", test_name);
                end
            // Busy just fell, so the whole job length is known
            if (busy_cnt != 0) begin
                assert (busy_cnt == job_k + FILL_CYCLES + job_m)
                    else begin
                        errors++;
                        $display("MISMATCH %s busy cycles expected %0d actual %0d",
                                 test_name, job_k + FILL_CYCLES + job_m, busy_cnt);
                    end
                busy_cnt = 0;
            end
            if (in_valid) begin
                acc_k = int'(k_in);
                acc_m = int'(m_in);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Reference model and stimulus
    // ------------------------------------------------------------------------

    function automatic logic [ELEM_W-1:0] elem_of(logic [OP_WORD_W-1:0] w, int p);
        return w[OP_WORD_W-1-p*ELEM_W -: ELEM_W];
    endfunction

    // Row r of A x B modulo 2^32
    // Zero outside the M x N tile
    function automatic logic [ROW_WORD_W-1:0] expected_row(int r, int k, int m, int n);
        logic [ROW_WORD_W-1:0] row;
        logic [ACC_W-1:0]      sum;
        row = '0;
        for (int c = 0; c < ARRAY_DIM; c++) begin
            sum = '0;
            if (r < m && c < n) begin
                for (int i = 0; i < k; i++) begin
                    sum += ACC_W'(elem_of(a_mem[ADDR_W'(i)], r)) *
                           ACC_W'(elem_of(b_mem[ADDR_W'(i)], c));
                end
            end
            row[ROW_WORD_W-1-c*ACC_W -: ACC_W] = sum;
        end
        return row;
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            a_mem[ADDR_W'(i)] = $urandom;
            b_mem[ADDR_W'(i)] = $urandom;
        end
    endtask

    // Called a little after a rising edge while the DUT is idle
    task automatic start_job(string name, int k, int m, int n);
        test_name = name;
        cur_m = m;
        for (int r = 0; r < ARRAY_DIM; r++) begin
            c_exp[ROW_SEL_W'(r)] = expected_row(r, k, m, n);
            c_mem[ROW_SEL_W'(r)] = '0;
            c_written[ROW_SEL_W'(r)] = 1'b0;
        end
        in_valid = 1'b1;
        k_in = DIM_W'(k);
        m_in = DIM_W'(m);
        n_in = DIM_W'(n);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        jobs++;
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_results();
        for (int r = 0; r < ARRAY_DIM; r++) begin
            if (r < cur_m) begin
                assert (c_written[ROW_SEL_W'(r)])
                    else begin
                        errors++;
                        $display("%s: C row %0d was never written", test_name, r);
                    end
                assert (c_mem[ROW_SEL_W'(r)] === c_exp[ROW_SEL_W'(r)])
                    else begin
                        errors++;
                        $display("MISMATCH %s C row %0d expected %h actual %h", test_name, r,
                                 c_exp[ROW_SEL_W'(r)], c_mem[ROW_SEL_W'(r)]);
                    end
            end else begin
                assert (!c_written[ROW_SEL_W'(r)])
                    else begin
                        errors++;
                        $display("%s: C row %0d written beyond M", test_name, r);
                    end
            end
        end
    endtask

    task automatic check_reset_outputs();
        assert (busy == 1'b0 && c_wr_en == 1'b0 && c_index == '0)
            else begin
                errors++;
                $display("MISMATCH %s busy/wr_en/index expected 0/0/0 actual %0b/%0b/%0d",
                         test_name, busy, c_wr_en, c_index);
            end
    endtask

    task automatic run_tile(string name, int j);
        fill_memories();
        start_job(name, JOB_K[j], JOB_M[j], JOB_N[j]);
        wait_idle();
        check_results();
    endtask

    initial begin
        void'($urandom(SEED));
        fill_memories();
        timeout_cycles = 50;
        for (int j = 0; j < NUM_JOBS; j++) begin
            timeout_cycles += JOB_K[j] + FILL_CYCLES + JOB_M[j] + 4;
        end
        rst_n = 1'b0;
        in_valid = 1'b0;
        k_in = '0;
        m_in = '0;
        n_in = '0;

        #5;
        check_reset_outputs();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        test_name = "after_reset";
        check_reset_outputs();
        @(posedge clk);
        #1;

        run_tile("full_tile", 0);
        run_tile("partial_tile", 1);
        run_tile("shortest_job", 2);

        // A start request during the drain must be ignored
        fill_memories();
        start_job("back_to_back_1", JOB_K[3], JOB_M[3], JOB_N[3]);
        while (!c_wr_en) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        k_in = DIM_W'(200);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        wait_idle();
        check_results();
        // Second job goes in on the flush cycle with fresh operands
        fill_memories();
        start_job("back_to_back_2", JOB_K[4], JOB_M[4], JOB_N[4]);
        wait_idle();
        check_results();
        @(negedge clk);
        @(posedge clk);

        $display("Jobs run: %0d, errors: %0d", jobs, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
